//--- src.f
hwpe_pkg.sv
apb_reg_bridge.sv
hwpe_job_fifo.sv
hwpe_stream_engine.sv
fc_hwpe.sv
tb_checker.sv
tb_fc_hwpe.sv

//--- Makefile
TOP := tb_fc_hwpe

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

//--- tb_fc_hwpe.sv
// testbench top with clock, reset, TCDM memory model, job table, APB driver and watchdog
`default_nettype none

module tb_fc_hwpe
    import hwpe_pkg::*;
();

    localparam int N_JOBS       = 10;
    localparam int FIRST_QUEUED = 3;
    localparam int JOB_DEPTH    = 4;
    localparam int MEM_WORDS    = 1024;

    logic        clk          = 1'b0;
    logic        reset        = 1'b1;
    logic        psel         = 1'b0;
    logic        penable      = 1'b0;
    logic        pwrite       = 1'b0;
    logic [11:0] paddr        = '0;
    logic [31:0] pwdata       = '0;
    logic        tcdm_gnt     = 1'b0;
    logic [31:0] tcdm_r_rdata = '0;
    logic        tcdm_r_valid = 1'b0;
    logic        stall        = 1'b0;
    logic        fin          = 1'b0;
    logic [31:0] rd_exp       = '0;
    logic [63:0] rd_tag       = '0;
    logic [15:0] lfsr         = 16'd50596;

    logic [31:0] prdata;
    logic        pready;
    logic        tcdm_req;
    logic [31:0] tcdm_add;
    logic        tcdm_wen;
    logic [3:0]  tcdm_be;
    logic [31:0] tcdm_wdata;
    logic [1:0]  evt;
    logic        busy;
    int          done_cnt;
    int          errors;
    logic [31:0] mem [MEM_WORDS];

    // the first three jobs run on their own, the rest are queued while the memory stalls
    // src regions sit below 0x800 and dst regions above, so sources are never overwritten
    logic [63:0] job_name [N_JOBS] = '{"add_wrap", "half_ovf", "zero_len", "queued_1",
        "queued_2", "queued_3", "queued_4", "queued_5", "dropped1", "dropped2"};
    logic [31:0] job_src [N_JOBS] = '{32'h000, 32'h040, 32'h080, 32'h100, 32'h120,
        32'h140, 32'h160, 32'h180, 32'h1A0, 32'h1C0};
    logic [31:0] job_dst [N_JOBS] = '{32'h800, 32'h840, 32'h880, 32'h900, 32'h920,
        32'h940, 32'h960, 32'h980, 32'h9A0, 32'h9C0};
    logic [LEN_W-1:0] job_len [N_JOBS] = '{16'd3, 16'd4, 16'd0, 16'd2, 16'd3,
        16'd1, 16'd4, 16'd2, 16'd2, 16'd3};
    logic [31:0] job_bias [N_JOBS] = '{32'hFFFF_FF00, 32'h8001_7FFF, 32'h0000_0001,
        32'h0000_0011, 32'h0001_0001, 32'hDEAD_BEEF, 32'hFFFF_FFFF, 32'h0000_0007,
        32'h0000_0000, 32'h0000_0005};
    logic job_op [N_JOBS] = '{OP_ADD32, OP_ADD16X2, OP_ADD32, OP_ADD32, OP_ADD16X2,
        OP_ADD32, OP_ADD16X2, OP_ADD32, OP_ADD32, OP_ADD16X2};
    logic job_ovf [N_JOBS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};

    always #5 clk = ~clk;

    fc_hwpe #(
        .JOB_DEPTH      ( JOB_DEPTH ),
        .APB_ADDR_WIDTH ( 12        )
    ) UUT (
        .clk_i          ( clk          ),
        .reset_i        ( reset        ),
        .psel_i         ( psel         ),
        .penable_i      ( penable      ),
        .pwrite_i       ( pwrite       ),
        .paddr_i        ( paddr        ),
        .pwdata_i       ( pwdata       ),
        .prdata_o       ( prdata       ),
        .pready_o       ( pready       ),
        .tcdm_req_o     ( tcdm_req     ),
        .tcdm_add_o     ( tcdm_add     ),
        .tcdm_wen_o     ( tcdm_wen     ),
        .tcdm_be_o      ( tcdm_be      ),
        .tcdm_wdata_o   ( tcdm_wdata   ),
        .tcdm_gnt_i     ( tcdm_gnt     ),
        .tcdm_r_rdata_i ( tcdm_r_rdata ),
        .tcdm_r_valid_i ( tcdm_r_valid ),
        .evt_o          ( evt          ),
        .busy_o         ( busy         )
    );

    tb_checker #(
        .N_JOBS ( N_JOBS )
    ) mon (
        .clk_i        ( clk        ),
        .reset_i      ( reset      ),
        .tcdm_req_i   ( tcdm_req   ),
        .tcdm_add_i   ( tcdm_add   ),
        .tcdm_wen_i   ( tcdm_wen   ),
        .tcdm_be_i    ( tcdm_be    ),
        .tcdm_wdata_i ( tcdm_wdata ),
        .tcdm_gnt_i   ( tcdm_gnt   ),
        .evt_i        ( evt        ),
        .busy_i       ( busy       ),
        .psel_i       ( psel       ),
        .penable_i    ( penable    ),
        .pwrite_i     ( pwrite     ),
        .prdata_i     ( prdata     ),
        .pready_i     ( pready     ),
        .rd_exp_i     ( rd_exp     ),
        .rd_tag_i     ( rd_tag     ),
        .job_name_i   ( job_name   ),
        .job_src_i    ( job_src    ),
        .job_dst_i    ( job_dst    ),
        .job_len_i    ( job_len    ),
        .job_bias_i   ( job_bias   ),
        .job_op_i     ( job_op     ),
        .job_ovf_i    ( job_ovf    ),
        .fin_i        ( fin        ),
        .done_cnt_o   ( done_cnt   ),
        .errors_o     ( errors     )
    );

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11, the new bit enters at bit 0
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int total_words();
        int n;
        n = 0;
        for (int k = 0; k < N_JOBS; k++) n += int'(job_len[k]);
        return n;
    endfunction

    function automatic int accepted_jobs();
        int n;
        n = 0;
        for (int k = 0; k < N_JOBS; k++) begin
            if (!job_ovf[k]) n++;
        end
        return n;
    endfunction

    // grant is a random ready signal, a request is taken when it meets the grant
    // the memory array lives only in this block
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] = mon.mem_rule(10'(i));
            end
            tcdm_gnt     <= 1'b0;
            tcdm_r_valid <= 1'b0;
        end else begin
            tcdm_r_valid <= 1'b0;
            if (tcdm_req && tcdm_gnt) begin
                if (tcdm_wen) begin
                    tcdm_r_valid <= 1'b1;
                    tcdm_r_rdata <= mem[tcdm_add[11:2]];
                end else begin
                    mem[tcdm_add[11:2]] = tcdm_wdata;
                end
            end
            if (stall) begin
                tcdm_gnt <= 1'b0;
            end else begin
                lfsr = lfsr_step(lfsr);
                tcdm_gnt <= lfsr[0];
            end
        end
    end

    task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= {7'h0, addr};
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [4:0] addr, input logic [31:0] exp,
                            input logic [63:0] tag);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= {7'h0, addr};
        rd_exp  <= exp;
        rd_tag  <= tag;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic program_job(input int k);
        apb_write(REG_SRC, job_src[k]);
        apb_write(REG_DST, job_dst[k]);
        apb_write(REG_LEN, 32'(job_len[k]));
        apb_write(REG_BIAS, job_bias[k]);
        apb_write(REG_CTRL, {31'h0, job_op[k]});
    endtask

    task automatic wait_for_done(input int n);
        while (done_cnt < n) @(posedge clk);
    endtask

    initial begin
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int k = 0; k < FIRST_QUEUED; k++) begin
            program_job(k);
        end
        wait_for_done(FIRST_QUEUED);
        // with the memory held off the engine keeps one job and the queue fills behind it
        stall <= 1'b1;
        for (int k = FIRST_QUEUED; k < N_JOBS; k++) begin
            program_job(k);
        end
        apb_read(REG_STATUS, {23'h0, 1'b1, 8'(JOB_DEPTH)}, "stat_mid");
        apb_read(REG_SRC, job_src[N_JOBS-1], "src_back");
        apb_read(REG_DST, job_dst[N_JOBS-1], "dst_back");
        apb_read(REG_LEN, 32'(job_len[N_JOBS-1]), "len_back");
        apb_read(REG_BIAS, job_bias[N_JOBS-1], "biasback");
        apb_read(REG_CTRL, 32'h0, "ctrlback");
        stall <= 1'b0;
        wait_for_done(accepted_jobs());
        repeat (4) @(posedge clk);
        apb_read(REG_STATUS, 32'h0, "stat_end");
        fin <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // budget of 60 cycles per word plus the APB traffic of each job
    initial begin
        longint limit;
        limit = 10 * (60 * longint'(total_words()) + 100 * N_JOBS + 400);
        #(limit);
        $display("watchdog: jobs did not complete within %0d time units", limit);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_checker.sv
// monitor that predicts TCDM traffic, counts events, compares APB reads and prints the totals
`default_nettype none

module tb_checker
    import hwpe_pkg::*;
#(
    parameter int N_JOBS = 10
) (
    input  wire logic             clk_i,
    input  wire logic             reset_i,
    input  wire logic             tcdm_req_i,
    input  wire logic [31:0]      tcdm_add_i,
    input  wire logic             tcdm_wen_i,
    input  wire logic [3:0]       tcdm_be_i,
    input  wire logic [31:0]      tcdm_wdata_i,
    input  wire logic             tcdm_gnt_i,
    input  wire logic [1:0]       evt_i,
    input  wire logic             busy_i,
    input  wire logic             psel_i,
    input  wire logic             penable_i,
    input  wire logic             pwrite_i,
    input  wire logic [31:0]      prdata_i,
    input  wire logic             pready_i,
    input  wire logic [31:0]      rd_exp_i,
    input  wire logic [63:0]      rd_tag_i,
    input  wire logic [63:0]      job_name_i [N_JOBS],
    input  wire logic [31:0]      job_src_i  [N_JOBS],
    input  wire logic [31:0]      job_dst_i  [N_JOBS],
    input  wire logic [LEN_W-1:0] job_len_i  [N_JOBS],
    input  wire logic [31:0]      job_bias_i [N_JOBS],
    input  wire logic             job_op_i   [N_JOBS],
    input  wire logic             job_ovf_i  [N_JOBS],
    input  wire logic             fin_i,
    output int                    done_cnt_o,
    output int                    errors_o
);

    int   cur;
    int   widx;
    int   value_errs;
    int   event_errs;
    int   ovf_cnt;
    logic fin_seen = 1'b0;

    assign errors_o = value_errs + event_errs;

    // initial memory contents, every address bit shows up in both halves of the word
    function automatic logic [31:0] mem_rule(input logic [9:0] idx);
        return {~idx, 6'h15, idx ^ 10'h3A7, idx[5:0]};
    endfunction

    // source word plus bias, either as one number or as two halves that wrap separately
    function automatic logic [31:0] expected_word(input int k, input int w);
        tcdm_word_u src_w;
        tcdm_word_u bias_w;
        tcdm_word_u res_w;
        src_w.word  = mem_rule(job_src_i[k][11:2] + 10'(w));
        bias_w.word = job_bias_i[k];
        if (job_op_i[k] == OP_ADD16X2) begin
            res_w.half[1] = src_w.half[1] + bias_w.half[1];
            res_w.half[0] = src_w.half[0] + bias_w.half[0];
        end else begin
            res_w.word = src_w.word + bias_w.word;
        end
        return res_w.word;
    endfunction

    // dropped jobs never reach the engine, so they are skipped in the expected order
    function automatic int next_accepted(input int from);
        int k;
        k = from;
        while (k < N_JOBS && job_ovf_i[k]) begin
            k++;
        end
        return k;
    endfunction

    function automatic int count_dropped();
        int n;
        n = 0;
        for (int k = 0; k < N_JOBS; k++) begin
            if (job_ovf_i[k]) n++;
        end
        return n;
    endfunction

    task automatic check_access();
        logic [31:0] exp_add;
        logic [31:0] exp_data;
        if (cur >= N_JOBS || widx >= int'(job_len_i[cur])) begin
            event_errs++;
            $display("TCDM %s at %h came with no word left in any job",
                     tcdm_wen_i ? "read" : "write", tcdm_add_i);
        end else begin
            // every access covers all four bytes of the word
            if (tcdm_be_i != 4'hF) begin
                value_errs++;
                $display("** Error %0s access %0d byte enable: expected %h, actual %h",
                         job_name_i[cur], widx, 4'hF, tcdm_be_i);
            end
            if (tcdm_wen_i) begin
                exp_add = job_src_i[cur] + 32'(4 * widx);
                if (tcdm_add_i != exp_add) begin
                    value_errs++;
                    $display("** Error %0s read %0d address: expected %h, actual %h",
                             job_name_i[cur], widx, exp_add, tcdm_add_i);
                end
            end else begin
                exp_add  = job_dst_i[cur] + 32'(4 * widx);
                exp_data = expected_word(cur, widx);
                if (tcdm_add_i != exp_add) begin
                    value_errs++;
                    $display("** Error %0s write %0d address: expected %h, actual %h",
                             job_name_i[cur], widx, exp_add, tcdm_add_i);
                end
                if (tcdm_wdata_i != exp_data) begin
                    value_errs++;
                    $display("** Error %0s write %0d data: expected %h, actual %h",
                             job_name_i[cur], widx, exp_data, tcdm_wdata_i);
                end
                widx++;
            end
        end
    endtask

    task automatic check_done();
        if (cur >= N_JOBS) begin
            event_errs++;
            $display("done event arrived with no job left to finish");
        end else begin
            if (widx != int'(job_len_i[cur])) begin
                event_errs++;
                $display("%0s signalled done after %0d of %0d words",
                         job_name_i[cur], widx, job_len_i[cur]);
            end
            cur  = next_accepted(cur + 1);
            widx = 0;
            done_cnt_o <= done_cnt_o + 1;
        end
    endtask

    always @(posedge clk_i) begin
        if (reset_i) begin
            cur  = next_accepted(0);
            widx = 0;
            done_cnt_o <= 0;
        end else begin
            if (tcdm_req_i && tcdm_gnt_i) check_access();
            if (evt_i[0]) check_done();
            if (evt_i[1]) ovf_cnt++;
            // the slave has no wait states, so ready simply follows enable
            if (pready_i != penable_i) begin
                value_errs++;
                $display("** Error apb_ready: expected %b, actual %b", penable_i, pready_i);
            end
            if (psel_i && penable_i && !pwrite_i && prdata_i != rd_exp_i) begin
                value_errs++;
                $display("** Error %0s: expected %h, actual %h", rd_tag_i, rd_exp_i, prdata_i);
            end
            if (fin_i && !fin_seen) begin
                fin_seen = 1'b1;
                if (cur < N_JOBS) begin
                    event_errs++;
                    $display("%0s never sent its done event", job_name_i[cur]);
                end
                if (ovf_cnt != count_dropped()) begin
                    event_errs++;
                    $display("expected %0d overflow events but saw %0d", count_dropped(), ovf_cnt);
                end
                if (busy_i) begin
                    event_errs++;
                    $display("busy stayed high after the last done event");
                end
                $display("error count: %0d value, %0d event", value_errs, event_errs);
            end
        end
    end

endmodule

`default_nettype wire

//--- fc_hwpe.sv
// top level joining the APB register bridge, the job queue and the stream engine
`default_nettype none

module fc_hwpe
    import hwpe_pkg::*;
#(
    parameter int unsigned JOB_DEPTH      = 4,
    parameter int unsigned APB_ADDR_WIDTH = 12
) (
    input  wire logic                      clk_i,
    input  wire logic                      reset_i,
    input  wire logic                      psel_i,
    input  wire logic                      penable_i,
    input  wire logic                      pwrite_i,
    input  wire logic [APB_ADDR_WIDTH-1:0] paddr_i,
    input  wire logic [31:0]               pwdata_i,
    output logic      [31:0]               prdata_o,
    output logic                           pready_o,
    output logic                           tcdm_req_o,
    output logic      [31:0]               tcdm_add_o,
    output logic                           tcdm_wen_o,
    output logic      [3:0]                tcdm_be_o,
    output logic      [31:0]               tcdm_wdata_o,
    input  wire logic                      tcdm_gnt_i,
    input  wire logic [31:0]               tcdm_r_rdata_i,
    input  wire logic                      tcdm_r_valid_i,
    output logic      [1:0]                evt_o,
    output logic                           busy_o
);

    logic             push;
    logic [31:0]      push_src;
    logic [31:0]      push_dst;
    logic [LEN_W-1:0] push_len;
    logic [31:0]      push_bias;
    logic             push_op;
    logic             q_full;
    logic [CNT_W-1:0] q_count;
    logic             q_not_empty;
    logic             pop;
    logic [31:0]      head_src;
    logic [31:0]      head_dst;
    logic [LEN_W-1:0] head_len;
    logic [31:0]      head_bias;
    logic             head_op;
    logic             eng_active;

    // busy covers both queued jobs and the one in flight
    assign busy_o = q_not_empty | eng_active;

    apb_reg_bridge #(
        .APB_ADDR_WIDTH ( APB_ADDR_WIDTH )
    ) i_apb_reg_bridge (
        .clk_i          ( clk_i       ),
        .reset_i        ( reset_i     ),
        .psel_i         ( psel_i      ),
        .penable_i      ( penable_i   ),
        .pwrite_i       ( pwrite_i    ),
        .paddr_i        ( paddr_i     ),
        .pwdata_i       ( pwdata_i    ),
        .prdata_o       ( prdata_o    ),
        .pready_o       ( pready_o    ),
        .job_push_o     ( push        ),
        .job_src_o      ( push_src    ),
        .job_dst_o      ( push_dst    ),
        .job_len_o      ( push_len    ),
        .job_bias_o     ( push_bias   ),
        .job_op_o       ( push_op     ),
        .job_full_i     ( q_full      ),
        .job_count_i    ( q_count     ),
        .busy_i         ( busy_o      ),
        .evt_overflow_o ( evt_o[1]    )
    );

    hwpe_job_fifo #(
        .JOB_DEPTH ( JOB_DEPTH )
    ) i_hwpe_job_fifo (
        .clk_i       ( clk_i       ),
        .reset_i     ( reset_i     ),
        .push_i      ( push        ),
        .src_i       ( push_src    ),
        .dst_i       ( push_dst    ),
        .len_i       ( push_len    ),
        .bias_i      ( push_bias   ),
        .op_i        ( push_op     ),
        .pop_i       ( pop         ),
        .head_src_o  ( head_src    ),
        .head_dst_o  ( head_dst    ),
        .head_len_o  ( head_len    ),
        .head_bias_o ( head_bias   ),
        .head_op_o   ( head_op     ),
        .not_empty_o ( q_not_empty ),
        .full_o      ( q_full      ),
        .count_o     ( q_count     )
    );

    hwpe_stream_engine i_hwpe_stream_engine (
        .clk_i          ( clk_i          ),
        .reset_i        ( reset_i        ),
        .job_valid_i    ( q_not_empty    ),
        .job_src_i      ( head_src       ),
        .job_dst_i      ( head_dst       ),
        .job_len_i      ( head_len       ),
        .job_bias_i     ( head_bias      ),
        .job_op_i       ( head_op        ),
        .job_pop_o      ( pop            ),
        .tcdm_req_o     ( tcdm_req_o     ),
        .tcdm_add_o     ( tcdm_add_o     ),
        .tcdm_wen_o     ( tcdm_wen_o     ),
        .tcdm_be_o      ( tcdm_be_o      ),
        .tcdm_wdata_o   ( tcdm_wdata_o   ),
        .tcdm_gnt_i     ( tcdm_gnt_i     ),
        .tcdm_r_rdata_i ( tcdm_r_rdata_i ),
        .tcdm_r_valid_i ( tcdm_r_valid_i ),
        .evt_done_o     ( evt_o[0]       ),
        .active_o       ( eng_active     )
    );

endmodule

`default_nettype wire

//--- hwpe_stream_engine.sv
// job consumer that reads each word over TCDM, adds the bias and writes the result back
`default_nettype none

module hwpe_stream_engine
    import hwpe_pkg::*;
(
    input  wire logic             clk_i,
    input  wire logic             reset_i,
    input  wire logic             job_valid_i,
    input  wire logic [31:0]      job_src_i,
    input  wire logic [31:0]      job_dst_i,
    input  wire logic [LEN_W-1:0] job_len_i,
    input  wire logic [31:0]      job_bias_i,
    input  wire logic             job_op_i,
    output logic                  job_pop_o,
    output logic                  tcdm_req_o,
    output logic      [31:0]      tcdm_add_o,
    output logic                  tcdm_wen_o,
    output logic      [3:0]       tcdm_be_o,
    output logic      [31:0]      tcdm_wdata_o,
    input  wire logic             tcdm_gnt_i,
    input  wire logic [31:0]      tcdm_r_rdata_i,
    input  wire logic             tcdm_r_valid_i,
    output logic                  evt_done_o,
    output logic                  active_o
);

    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_RD_REQ = 3'd1;
    localparam logic [2:0] ST_RD_RSP = 3'd2;
    localparam logic [2:0] ST_WR_REQ = 3'd3;
    localparam logic [2:0] ST_DONE   = 3'd4;

    logic [2:0]       state_q;
    logic [2:0]       state_d;
    logic [31:0]      src_addr_q;
    logic [31:0]      dst_addr_q;
    logic [LEN_W-1:0] remain_q;
    tcdm_word_u       bias_q;
    logic             op_q;
    logic [31:0]      wdata_q;
    tcdm_word_u       rdata_w;
    tcdm_word_u       sum_w;
    logic             wr_done;
    logic             rd_back;

    assign job_pop_o = (state_q == ST_IDLE) && job_valid_i;
    assign wr_done   = (state_q == ST_WR_REQ) && tcdm_gnt_i;
    assign rd_back   = (state_q == ST_RD_RSP) && tcdm_r_valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                // an empty job skips straight to the done pulse
                if (job_valid_i) begin
                    state_d = (job_len_i == '0) ? ST_DONE : ST_RD_REQ;
                end
            end
            ST_RD_REQ: begin
                if (tcdm_gnt_i) state_d = ST_RD_RSP;
            end
            ST_RD_RSP: begin
                if (tcdm_r_valid_i) state_d = ST_WR_REQ;
            end
            ST_WR_REQ: begin
                if (tcdm_gnt_i) begin
                    state_d = (remain_q == LEN_W'(1)) ? ST_DONE : ST_RD_REQ;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // the halves mode adds each half on its own so no carry crosses bit 16
    assign rdata_w = tcdm_r_rdata_i;

    always_comb begin
        if (op_q == OP_ADD16X2) begin
            sum_w.half[1] = rdata_w.half[1] + bias_q.half[1];
            sum_w.half[0] = rdata_w.half[0] + bias_q.half[0];
        end else begin
            sum_w.word = rdata_w.word + bias_q.word;
        end
    end

    always_ff @(posedge clk_i) begin
        if (job_pop_o) begin
            src_addr_q <= job_src_i;
            dst_addr_q <= job_dst_i;
            remain_q   <= job_len_i;
            bias_q     <= job_bias_i;
            op_q       <= job_op_i;
        end else if (wr_done) begin
            src_addr_q <= src_addr_q + 32'd4;
            dst_addr_q <= dst_addr_q + 32'd4;
            remain_q   <= remain_q - 1'b1;
        end
        if (rd_back) begin
            wdata_q <= sum_w.word;
        end
    end

    assign tcdm_req_o   = (state_q == ST_RD_REQ) || (state_q == ST_WR_REQ);
    assign tcdm_wen_o   = (state_q != ST_WR_REQ);
    assign tcdm_add_o   = (state_q == ST_WR_REQ) ? dst_addr_q : src_addr_q;
    assign tcdm_be_o    = 4'hF;
    assign tcdm_wdata_o = wdata_q;

    assign evt_done_o = (state_q == ST_DONE);
    assign active_o   = (state_q != ST_IDLE);

    // a pending request must hold its fields until the memory side grants it
    assert property (@(posedge clk_i) disable iff (reset_i)
        tcdm_req_o && !tcdm_gnt_i |=> tcdm_req_o && $stable(tcdm_add_o) &&
            $stable(tcdm_wen_o) && $stable(tcdm_wdata_o))
        else $error("TCDM request changed before grant");

endmodule

`default_nettype wire

//--- hwpe_job_fifo.sv
// circular queue of pending job records with fill level output
`default_nettype none

module hwpe_job_fifo
    import hwpe_pkg::*;
#(
    parameter int unsigned JOB_DEPTH = 4
) (
    input  wire logic                   clk_i,
    input  wire logic                   reset_i,
    input  wire logic                   push_i,
    input  wire logic [31:0]            src_i,
    input  wire logic [31:0]            dst_i,
    input  wire logic [LEN_W-1:0]       len_i,
    input  wire logic [31:0]            bias_i,
    input  wire logic                   op_i,
    input  wire logic                   pop_i,
    output logic      [31:0]            head_src_o,
    output logic      [31:0]            head_dst_o,
    output logic      [LEN_W-1:0]       head_len_o,
    output logic      [31:0]            head_bias_o,
    output logic                        head_op_o,
    output logic                        not_empty_o,
    output logic                        full_o,
    output logic      [CNT_W-1:0]       count_o
);

    localparam int unsigned PTR_W  = $clog2(JOB_DEPTH);
    localparam int unsigned FILL_W = $clog2(JOB_DEPTH + 1);

    logic [31:0]       src_mem  [JOB_DEPTH];
    logic [31:0]       dst_mem  [JOB_DEPTH];
    logic [LEN_W-1:0]  len_mem  [JOB_DEPTH];
    logic [31:0]       bias_mem [JOB_DEPTH];
    logic              op_mem   [JOB_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [FILL_W-1:0] fill_q;
    logic              do_push;
    logic              do_pop;

    assign not_empty_o = (fill_q != '0);
    assign full_o      = (fill_q == FILL_W'(JOB_DEPTH));
    assign count_o     = CNT_W'(fill_q);

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & not_empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            src_mem[wr_ptr_q]  <= src_i;
            dst_mem[wr_ptr_q]  <= dst_i;
            len_mem[wr_ptr_q]  <= len_i;
            bias_mem[wr_ptr_q] <= bias_i;
            op_mem[wr_ptr_q]   <= op_i;
        end
    end

    // pointers wrap by themselves since the depth is a power of two
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
        end else begin
            if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            fill_q <= fill_q + FILL_W'(do_push) - FILL_W'(do_pop);
        end
    end

    assign head_src_o  = src_mem[rd_ptr_q];
    assign head_dst_o  = dst_mem[rd_ptr_q];
    assign head_len_o  = len_mem[rd_ptr_q];
    assign head_bias_o = bias_mem[rd_ptr_q];
    assign head_op_o   = op_mem[rd_ptr_q];

    // the engine only pops a job it has seen, the bridge never pushes into a full queue
    assert property (@(posedge clk_i) disable iff (reset_i) pop_i |-> not_empty_o)
        else $error("job queue popped while empty");
    assert property (@(posedge clk_i) disable iff (reset_i) push_i |-> !full_o)
        else $error("job queue pushed while full");

endmodule

`default_nettype wire

//--- apb_reg_bridge.sv
// APB slave holding the job staging registers, status readback, job push and overflow event
`default_nettype none

module apb_reg_bridge
    import hwpe_pkg::*;
#(
    parameter int unsigned APB_ADDR_WIDTH = 12
) (
    input  wire logic                      clk_i,
    input  wire logic                      reset_i,
    input  wire logic                      psel_i,
    input  wire logic                      penable_i,
    input  wire logic                      pwrite_i,
    input  wire logic [APB_ADDR_WIDTH-1:0] paddr_i,
    input  wire logic [31:0]               pwdata_i,
    output logic      [31:0]               prdata_o,
    output logic                           pready_o,
    output logic                           job_push_o,
    output logic      [31:0]               job_src_o,
    output logic      [31:0]               job_dst_o,
    output logic      [LEN_W-1:0]          job_len_o,
    output logic      [31:0]               job_bias_o,
    output logic                           job_op_o,
    input  wire logic                      job_full_i,
    input  wire logic [CNT_W-1:0]          job_count_i,
    input  wire logic                      busy_i,
    output logic                           evt_overflow_o
);

    logic [4:0]       reg_addr;
    logic             wr_en;
    logic             ctrl_wr;
    logic [31:0]      src_q;
    logic [31:0]      dst_q;
    logic [LEN_W-1:0] len_q;
    logic [31:0]      bias_q;
    logic             overflow_q;

    // no wait states, every access completes in its access phase
    assign pready_o = penable_i;

    assign reg_addr = paddr_i[4:0];
    assign wr_en    = psel_i & penable_i & pwrite_i;
    assign ctrl_wr  = wr_en && (reg_addr == REG_CTRL);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            src_q  <= '0;
            dst_q  <= '0;
            len_q  <= '0;
            bias_q <= '0;
        end else if (wr_en) begin
            case (reg_addr)
                REG_SRC:  src_q  <= pwdata_i;
                REG_DST:  dst_q  <= pwdata_i;
                REG_LEN:  len_q  <= pwdata_i[LEN_W-1:0];
                REG_BIAS: bias_q <= pwdata_i;
                default:  ;
            endcase
        end
    end

    // the job enters the queue at the same edge that completes the control write
    assign job_push_o = ctrl_wr & ~job_full_i;
    assign job_src_o  = src_q;
    assign job_dst_o  = dst_q;
    assign job_len_o  = len_q;
    assign job_bias_o = bias_q;
    assign job_op_o   = pwdata_i[0] ? OP_ADD16X2 : OP_ADD32;

    // a control write into a full queue is dropped and flagged one cycle later
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            overflow_q <= 1'b0;
        end else begin
            overflow_q <= ctrl_wr & job_full_i;
        end
    end

    assign evt_overflow_o = overflow_q;

    always_comb begin
        prdata_o = '0;
        case (reg_addr)
            REG_SRC:    prdata_o = src_q;
            REG_DST:    prdata_o = dst_q;
            REG_LEN:    prdata_o = {{(32-LEN_W){1'b0}}, len_q};
            REG_BIAS:   prdata_o = bias_q;
            REG_STATUS: prdata_o = {{(31-CNT_W){1'b0}}, busy_i, job_count_i};
            default:    prdata_o = '0;
        endcase
    end

    // the APB master must open every transfer with a setup phase
    assert property (@(posedge clk_i) disable iff (reset_i) penable_i |-> psel_i)
        else $error("penable without psel on the APB port");

endmodule

`default_nettype wire

//--- hwpe_pkg.sv
// register offsets, operation codes, field widths and the data word union of the engine
`default_nettype none

package hwpe_pkg;

    // byte offsets of the APB registers, only the low 5 address bits are decoded
    localparam logic [4:0] REG_SRC    = 5'h00;
    localparam logic [4:0] REG_DST    = 5'h04;
    localparam logic [4:0] REG_LEN    = 5'h08;
    localparam logic [4:0] REG_BIAS   = 5'h0C;
    localparam logic [4:0] REG_CTRL   = 5'h10;
    localparam logic [4:0] REG_STATUS = 5'h14;

    // operation select, taken from bit 0 of the control write
    localparam logic OP_ADD32   = 1'b0;
    localparam logic OP_ADD16X2 = 1'b1;

    // width of the per-job word count
    localparam int unsigned LEN_W = 16;

    // width of the queue fill level as reported in the status register
    localparam int unsigned CNT_W = 8;

    // one TCDM data word, seen either as a single number or as two halves
    // half[1] is the upper 16 bits and half[0] the lower 16 bits
    typedef union packed {
        logic [31:0]      word;
        logic [1:0][15:0] half;
    } tcdm_word_u;

endpackage

`default_nettype wire
